/* source/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// First fetch address after reset.
`define MIPS_RESET_VECTOR 32'h0000_0004
// A jump or branch to this address stops the CPU.
`define MIPS_HALT_ADDR    32'h0000_0000
// Default RAM depth in 32-bit words.
`define RAM_WORDS         256

// Primary opcodes.
`define MIPS_OP_SPECIAL   6'h00
`define MIPS_OP_J         6'h02
`define MIPS_OP_BEQ       6'h04
`define MIPS_OP_ADDIU     6'h09
`define MIPS_OP_ORI       6'h0d
`define MIPS_OP_LUI       6'h0f
`define MIPS_OP_LW        6'h23
`define MIPS_OP_SW        6'h2b

// Function codes for the SPECIAL opcode.
`define MIPS_FN_JR        6'h08
`define MIPS_FN_ADDU      6'h21
`define MIPS_FN_SUBU      6'h23
`define MIPS_FN_AND       6'h24
`define MIPS_FN_OR        6'h25
`define MIPS_FN_XOR       6'h26
`define MIPS_FN_SLTU      6'h2b

`endif

/* source/mips_pkg.sv */
package mips_pkg;

    // Register format.
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // Immediate format.
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Jump format.
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // One instruction word seen through each format.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } mips_instr_t;

    // Master side of the memory-mapped bus.
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] address;
        logic [31:0] writedata;
    } bus_req_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLTU, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK, ST_HALTED
    } cpu_state_t;

endpackage

/* source/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    // Register 0 is never written, so it reads as zero after reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read ports.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // Return value register.
    assign v0 = regs[2];

endmodule

/* source/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu
    import mips_pkg::*;
(
    input  alu_op_t     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLTU: begin
                // Unsigned compare.
                result = {31'd0, a < b};
            end
            ALU_LUI: begin
                // Immediate moved to the upper half.
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Equality test for BEQ.
    assign zero = (result == 32'd0);

endmodule

/* source/mips_cpu.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_cpu
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    output bus_req_t    bus,
    input  logic [31:0] readdata,
    input  logic        waitrequest,
    output logic        active,
    output logic [31:0] register_v0
);

    cpu_state_t  state;
    mips_instr_t ir;
    logic [31:0] pc;
    logic [31:0] target;
    logic        taken_q;
    logic        delay_q;
    logic [31:0] a_q;
    logic [31:0] b_q;
    logic [31:0] alu_q;
    logic [31:0] mdr;

    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [31:0] pc_plus4;
    logic [31:0] jump_target;
    logic        jump_taken;

    alu_op_t     alu_op;
    logic        use_imm;
    logic        reg_write;
    logic [4:0]  dest;
    logic        is_load;
    logic        is_store;
    logic        is_beq;
    logic        is_jump;
    logic        is_jr;
    logic        illegal;

    // Instruction decode.
    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        imm_ext   = {{16{ir.i.imm[15]}}, ir.i.imm};
        reg_write = 1'b0;
        dest      = ir.i.rt;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_beq    = 1'b0;
        is_jump   = 1'b0;
        is_jr     = 1'b0;
        illegal   = 1'b0;
        case (ir.r.opcode)
            `MIPS_OP_SPECIAL: begin
                dest      = ir.r.rd;
                reg_write = 1'b1;
                case (ir.r.funct)
                    `MIPS_FN_ADDU: alu_op = ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = ALU_SUB;
                    `MIPS_FN_AND:  alu_op = ALU_AND;
                    `MIPS_FN_OR:   alu_op = ALU_OR;
                    `MIPS_FN_XOR:  alu_op = ALU_XOR;
                    `MIPS_FN_SLTU: alu_op = ALU_SLTU;
                    `MIPS_FN_JR: begin
                        reg_write = 1'b0;
                        is_jr     = 1'b1;
                    end
                    default: begin
                        reg_write = 1'b0;
                        illegal   = 1'b1;
                    end
                endcase
            end
            `MIPS_OP_ADDIU: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            `MIPS_OP_ORI: begin
                alu_op    = ALU_OR;
                use_imm   = 1'b1;
                imm_ext   = {16'h0000, ir.i.imm};
                reg_write = 1'b1;
            end
            `MIPS_OP_LUI: begin
                alu_op    = ALU_LUI;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            `MIPS_OP_LW: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                is_load   = 1'b1;
            end
            `MIPS_OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            `MIPS_OP_BEQ: begin
                alu_op = ALU_SUB;
                is_beq = 1'b1;
            end
            `MIPS_OP_J: is_jump = 1'b1;
            default:    illegal = 1'b1;
        endcase
    end

    assign alu_b    = use_imm ? imm_ext : b_q;
    assign pc_plus4 = pc + 32'd4;

    // Targets are relative to the delay slot address.
    always_comb begin
        if (is_jr) begin
            jump_target = a_q;
        end else if (is_jump) begin
            jump_target = {pc_plus4[31:28], ir.j.target, 2'b00};
        end else begin
            jump_target = pc_plus4 + {imm_ext[29:0], 2'b00};
        end
    end

    assign jump_taken = is_jr || is_jump || (is_beq && alu_zero);

    // Address and data come from registers, so they hold under waitrequest.
    always_comb begin
        bus.read      = (state == ST_FETCH) || ((state == ST_MEMORY) && is_load);
        bus.write     = (state == ST_MEMORY) && is_store;
        bus.address   = (state == ST_FETCH) ? pc : alu_q;
        bus.writedata = b_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            pc      <= `MIPS_RESET_VECTOR;
            taken_q <= 1'b0;
            delay_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: state <= ST_FETCH;
                ST_FETCH: begin
                    if (!waitrequest) begin
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: state <= illegal ? ST_HALTED : ST_EXECUTE;
                ST_EXECUTE: begin
                    taken_q <= jump_taken;
                    state   <= (is_load || is_store) ? ST_MEMORY : ST_WRITEBACK;
                end
                ST_MEMORY: begin
                    if (!waitrequest) begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    // A taken jump arms the redirect for after its delay slot.
                    delay_q <= taken_q;
                    taken_q <= 1'b0;
                    if (delay_q) begin
                        pc    <= target;
                        state <= (target == `MIPS_HALT_ADDR) ? ST_HALTED : ST_FETCH;
                    end else begin
                        pc    <= pc_plus4;
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_HALTED;
            endcase
        end
    end

    // Datapath registers.
    always_ff @(posedge clk) begin
        if ((state == ST_FETCH) && !waitrequest) begin
            ir <= readdata;
        end
        if (state == ST_DECODE) begin
            a_q <= rs_data;
            b_q <= rt_data;
        end
        if (state == ST_EXECUTE) begin
            alu_q <= alu_result;
            if (jump_taken) begin
                target <= jump_target;
            end
        end
        if ((state == ST_MEMORY) && !waitrequest) begin
            mdr <= readdata;
        end
    end

    assign active = (state != ST_IDLE) && (state != ST_HALTED);

    mips_regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (ir.i.rs),
        .rt_addr (ir.i.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   ((state == ST_WRITEBACK) && reg_write),
        .wr_addr (dest),
        .wr_data (is_load ? mdr : alu_q),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .op     (alu_op),
        .a      (a_q),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

endmodule

/* source/word_ram.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module word_ram
    import mips_pkg::*;
#(
    parameter int WORDS = `RAM_WORDS
) (
    input  logic        clk,
    input  logic        arst_n,
    input  bus_req_t    bus,
    output logic [31:0] readdata,
    output logic        waitrequest,
    input  logic        load_en,
    input  logic [7:0]  load_addr,
    input  logic [31:0] load_data
);

    localparam int AW = $clog2(WORDS);

    logic [31:0]   mem [WORDS];
    logic          pending;
    logic          strobe;
    logic [AW-1:0] bus_idx;
    logic [AW-1:0] load_idx;

    assign strobe   = bus.read || bus.write;
    assign bus_idx  = bus.address[AW+1:2];
    assign load_idx = AW'(load_addr[7:2]);

    // First cycle of each access waits, the second completes.
    assign waitrequest = strobe && !pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= strobe && !pending;
        end
    end

    // Preload takes priority over the bus.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (bus.write && !waitrequest) begin
            mem[bus_idx] <= bus.writedata;
        end
    end

    // Read data is captured during the wait cycle.
    always_ff @(posedge clk) begin
        if (bus.read && waitrequest) begin
            readdata <= mem[bus_idx];
        end
    end

endmodule

/* source/mips_system.sv */
`timescale 1ns/1ps

module mips_system
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        load_en,
    input  logic [7:0]  load_addr,
    input  logic [31:0] load_data,
    output logic        active,
    output logic [31:0] register_v0
);

    bus_req_t    bus;
    logic [31:0] readdata;
    logic        waitrequest;

    mips_cpu u_cpu (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus         (bus),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .active      (active),
        .register_v0 (register_v0)
    );

    word_ram u_ram (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus         (bus),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

endmodule

/* dv/mips_system_props.sv */
`timescale 1ns/1ps

module mips_system_props
    import mips_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input bus_req_t   bus,
    input logic       waitrequest,
    input logic       active,
    input cpu_state_t state
);

    // Only one strobe at a time.
    one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(bus.read && bus.write))
        else $error("read and write strobes high together");

    // Request held while the slave stalls.
    hold_on_wait: assert property (@(posedge clk) disable iff (!arst_n)
        (bus.read || bus.write) && waitrequest |=> $stable(bus))
        else $error("bus request changed under waitrequest");

    // Active stays low after the halt.
    halted_inactive: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ST_HALTED) |=> !active)
        else $error("active high again after the halt");

    // Halted is final until the next reset.
    halted_sticks: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ST_HALTED) |=> (state == ST_HALTED))
        else $error("CPU left the halted state");

endmodule

bind mips_cpu mips_system_props u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .bus         (bus),
    .waitrequest (waitrequest),
    .active      (active),
    .state       (state)
);

/* dv/mips_system_tb.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_system_tb;

    parameter int unsigned SEED = 32'h3c64;

    logic        clk;
    logic        arst_n;
    logic        load_en;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic        active;
    logic [31:0] register_v0;

    // Words placed from the reset vector upward.
    logic [31:0] program_words [$];

    mips_system UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] funct);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Byte address in, word index field out.
    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [31:0] addr);
        return {op, addr[27:2]};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // JR to address 0 with a harmless delay slot.
    task automatic append_halt();
        program_words.push_back(r_word(5'd0, 5'd0, 5'd0, `MIPS_FN_JR));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd0, 5'd0, 16'h0000));
    endtask

    task automatic load_program();
        @(posedge clk);
        arst_n <= 1'b0;
        foreach (program_words[k]) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= 8'(`MIPS_RESET_VECTOR + 4 * k);
            load_data <= program_words[k];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic run_to_halt();
        int cycles;
        cycles = 0;
        @(posedge clk);
        arst_n <= 1'b1;
        // Still idle right after release, fetching one cycle later.
        @(negedge clk);
        compare_value("active", active, 32'd0);
        @(negedge clk);
        compare_value("active", active, 32'd1);
        while (active && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            $display("Timed out waiting for the CPU to halt");
            $display("sim failed");
            $fatal(1, "halt timeout");
        end
    endtask

    task automatic reference_program();
        program_words.delete();
        program_words.push_back(r_word(5'd0, 5'd0, 5'd0, `MIPS_FN_JR));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd0, 5'd2, 16'h0010));
        load_program();
        run_to_halt();
        compare_value("register_v0", register_v0, 32'h0000_0010);
    endtask

    task automatic alu_operations();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic [5:0]  functs [6];
        functs = '{`MIPS_FN_ADDU, `MIPS_FN_SUBU, `MIPS_FN_AND,
                   `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_SLTU};
        a = $urandom();
        b = $urandom();
        for (int n = 0; n < 6; n++) begin
            case (functs[n])
                `MIPS_FN_ADDU: expected = a + b;
                `MIPS_FN_SUBU: expected = a - b;
                `MIPS_FN_AND:  expected = a & b;
                `MIPS_FN_OR:   expected = a | b;
                `MIPS_FN_XOR:  expected = a ^ b;
                default:       expected = (a < b) ? 32'd1 : 32'd0;
            endcase
            program_words.delete();
            program_words.push_back(i_word(`MIPS_OP_LUI, 5'd0, 5'd8, a[31:16]));
            program_words.push_back(i_word(`MIPS_OP_ORI, 5'd8, 5'd8, a[15:0]));
            program_words.push_back(i_word(`MIPS_OP_LUI, 5'd0, 5'd9, b[31:16]));
            program_words.push_back(i_word(`MIPS_OP_ORI, 5'd9, 5'd9, b[15:0]));
            program_words.push_back(r_word(5'd8, 5'd9, 5'd2, functs[n]));
            append_halt();
            load_program();
            run_to_halt();
            compare_value("register_v0", register_v0, expected);
        end
    endtask

    task automatic store_then_load();
        logic [31:0] c;
        c = $urandom();
        program_words.delete();
        program_words.push_back(i_word(`MIPS_OP_LUI, 5'd0, 5'd8, c[31:16]));
        program_words.push_back(i_word(`MIPS_OP_ORI, 5'd8, 5'd8, c[15:0]));
        program_words.push_back(i_word(`MIPS_OP_SW, 5'd0, 5'd8, 16'h0080));
        program_words.push_back(i_word(`MIPS_OP_LW, 5'd0, 5'd2, 16'h0080));
        append_halt();
        load_program();
        run_to_halt();
        compare_value("register_v0", register_v0, c);
    endtask

    // Taken branch skips 0x100, not taken runs 0x400, both delay slots run.
    task automatic branch_both_ways();
        program_words.delete();
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd0, 5'd8, 16'd5));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd0, 5'd9, 16'd5));
        program_words.push_back(i_word(`MIPS_OP_BEQ, 5'd8, 5'd9, 16'd2));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd2, 5'd2, 16'h0100));
        program_words.push_back(i_word(`MIPS_OP_BEQ, 5'd8, 5'd0, 16'd2));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd2, 5'd2, 16'h0020));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd2, 5'd2, 16'h0400));
        append_halt();
        load_program();
        run_to_halt();
        compare_value("register_v0", register_v0, 32'h0001 + 32'h0020 + 32'h0400);
    endtask

    task automatic jump_over_write();
        program_words.delete();
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd0, 5'd2, 16'h0033));
        program_words.push_back(j_word(`MIPS_OP_J, 32'h0000_0014));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd0, 5'd2, 16'h07ff));
        append_halt();
        load_program();
        run_to_halt();
        compare_value("register_v0", register_v0, 32'h0000_0034);
    endtask

    task automatic unknown_opcode_halts();
        program_words.delete();
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd0, 5'd2, 16'h0007));
        program_words.push_back(i_word(6'h3f, 5'd0, 5'd2, 16'h0009));
        program_words.push_back(i_word(`MIPS_OP_ADDIU, 5'd0, 5'd2, 16'h0009));
        append_halt();
        load_program();
        run_to_halt();
        compare_value("register_v0", register_v0, 32'h0000_0007);
    endtask

    initial begin
        arst_n    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        reference_program();
        alu_operations();
        store_then_load();
        branch_both_ways();
        jump_over_write();
        unknown_opcode_halts();
        $display("sim passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
source/mips_pkg.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_cpu.sv
source/word_ram.sv
source/mips_system.sv
dv/mips_system_props.sv
dv/mips_system_tb.sv

/* Makefile */
# Verilator build and run for the MIPS system testbench.
# A new SEED needs a rebuild, for example: make clean run SEED=1234

VERILATOR ?= verilator
TOP       ?= mips_system_tb
SEED      ?= 15460
FILELIST  ?= tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) source/mips_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f $(FILELIST)

# Pass only when the pass message shows up in the output.
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

clean:
	rm -rf $(OBJ_DIR)
